// ==== build.f ====
bus_defs_pkg.sv
mem_defs_pkg.sv
bus_sync.sv
reg_ctrl.sv
vram_mem.sv
xr_regs.sv
tick_timer.sv
intr_ctrl.sv
video_regs_top.sv
tb_video_regs.sv

// ==== bus_defs_pkg.sv ====
// ----------------------------------------------------------------------
// CPU bus definitions for the video register block
//   byte, word and address types
//   register numbers of the host register map
//   bus event struct passed from the bus synchronizer
// ----------------------------------------------------------------------
package bus_defs_pkg;

    typedef logic [7:0]  byte_t;                // one bus byte
    typedef logic [15:0] word_t;                // one register word
    typedef logic [15:0] addr_t;                // memory address

    localparam logic [3:0] REG_SYS_CTRL = 4'd0;
    localparam logic [3:0] REG_INT_CTRL = 4'd1;
    localparam logic [3:0] REG_TIMER    = 4'd2;
    localparam logic [3:0] REG_RD_XADDR = 4'd3;
    localparam logic [3:0] REG_WR_XADDR = 4'd4;
    localparam logic [3:0] REG_XDATA    = 4'd5;
    localparam logic [3:0] REG_RD_INCR  = 4'd6;
    localparam logic [3:0] REG_RD_ADDR  = 4'd7;
    localparam logic [3:0] REG_WR_INCR  = 4'd8;
    localparam logic [3:0] REG_WR_ADDR  = 4'd9;
    localparam logic [3:0] REG_DATA     = 4'd10;  // 11 to 15 alias on reads

    typedef struct packed {
        logic       wr_stb;                     // one-cycle write event
        logic       rd_stb;                     // one-cycle read event
        logic [3:0] reg_num;
        logic       bytesel;                    // 0 even (high), 1 odd (low)
        byte_t      data;
    } bus_evt_t;

endpackage

// ==== bus_sync.sv ====
// ----------------------------------------------------------------------
// CPU bus synchronizer
//   double-flops the asynchronous bus pins
//   turns the chip-select falling edge into one-cycle read or write
//   events with register number, byte select and data
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module bus_sync (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bus_cs_n_i,
    input  logic                   bus_rd_nwr_i,
    input  logic [3:0]             bus_reg_num_i,
    input  logic                   bus_bytesel_i,
    input  bus_defs_pkg::byte_t    bus_data_i,
    output bus_defs_pkg::bus_evt_t evt_o
);
    import bus_defs_pkg::*;

    logic       cs_n_meta, cs_n_sync, cs_n_prev;
    logic       rd_nwr_meta, rd_nwr_sync;
    logic       bytesel_meta, bytesel_sync;
    logic [3:0] reg_num_meta, reg_num_sync;
    byte_t      data_meta, data_sync;
    logic       cs_fall;

    assign cs_fall = cs_n_prev & ~cs_n_sync;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_meta <= 1'b1;                  // idle high so no false edge
            cs_n_sync <= 1'b1;
            cs_n_prev <= 1'b1;
        end else begin
            cs_n_meta <= bus_cs_n_i;
            cs_n_sync <= cs_n_meta;
            cs_n_prev <= cs_n_sync;
        end
    end

    always_ff @(posedge clk) begin
        rd_nwr_meta  <= bus_rd_nwr_i;
        rd_nwr_sync  <= rd_nwr_meta;
        bytesel_meta <= bus_bytesel_i;
        bytesel_sync <= bytesel_meta;
        reg_num_meta <= bus_reg_num_i;
        reg_num_sync <= reg_num_meta;
        data_meta    <= bus_data_i;
        data_sync    <= data_meta;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            evt_o.wr_stb <= 1'b0;
            evt_o.rd_stb <= 1'b0;
        end else begin
            evt_o.wr_stb <= cs_fall & ~rd_nwr_sync;
            evt_o.rd_stb <= cs_fall & rd_nwr_sync;
        end
        if (cs_fall) begin                      // held until the next access
            evt_o.reg_num <= reg_num_sync;
            evt_o.bytesel <= bytesel_sync;
            evt_o.data    <= data_sync;
        end
    end

endmodule

// ==== intr_ctrl.sv ====
// ----------------------------------------------------------------------
// interrupt controller
//   pending bits set by timer and vertical blank rise
//   CPU clear and mask, registered interrupt output
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module intr_ctrl (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                timer_intr_i,
    input  logic                v_blank_i,
    input  mem_defs_pkg::intr_t mask_i,
    input  mem_defs_pkg::intr_t clear_i,
    output mem_defs_pkg::intr_t status_o,
    output logic                intr_o
);
    import mem_defs_pkg::*;

    logic  v_blank_prev;
    intr_t set;

    assign set = {5'b0, v_blank_i & ~v_blank_prev, timer_intr_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            v_blank_prev <= 1'b0;
            status_o     <= '0;
            intr_o       <= 1'b0;
        end else begin
            v_blank_prev <= v_blank_i;
            status_o     <= (status_o & ~clear_i) | set;   // set beats clear
            intr_o       <= |(status_o & mask_i);
        end
    end

endmodule

// ==== mem_defs_pkg.sv ====
// ----------------------------------------------------------------------
// memory side definitions
//   VRAM and XR address widths, timer tick length
//   interrupt vector type
//   memory request struct shared by VRAM and XR blocks
// ----------------------------------------------------------------------
package mem_defs_pkg;

    localparam int VRAM_AW    = 8;            // 256 words
    localparam int XR_AW      = 4;            // 16 words
    localparam int TIMER_TICK = 8;            // clocks per timer count

    // bit 0 timer, bit 1 vertical blank
    typedef logic [6:0] intr_t;

    typedef struct packed {
        logic                vram_sel;
        logic                xr_sel;
        logic                wr;
        logic [3:0]          wrmask;          // VRAM nibble enables
        bus_defs_pkg::addr_t addr;
        bus_defs_pkg::word_t data;
    } mem_req_t;

endpackage

// ==== reg_ctrl.sv ====
// ----------------------------------------------------------------------
// host register control
//   address, increment, compare and mask registers
//   VRAM and XR requests with read prefetch, address update on ack
//   timer low byte latch and read data mux
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module reg_ctrl (
    input  logic                   clk,
    input  logic                   reset_i,
    input  bus_defs_pkg::bus_evt_t evt_i,
    output bus_defs_pkg::byte_t    bus_data_o,
    output mem_defs_pkg::mem_req_t mem_req_o,
    input  logic                   vram_ack_i,
    input  logic                   xr_ack_i,
    input  bus_defs_pkg::word_t    vram_rdata_i,
    input  bus_defs_pkg::word_t    xr_rdata_i,
    input  logic                   v_blank_i,
    input  bus_defs_pkg::word_t    timer_count_i,
    output bus_defs_pkg::word_t    timer_cmp_o,
    output mem_defs_pkg::intr_t    intr_mask_o,
    output mem_defs_pkg::intr_t    intr_clear_o,
    input  mem_defs_pkg::intr_t    intr_status_i
);
    import bus_defs_pkg::*;

    addr_t rd_xaddr, wr_xaddr;
    addr_t rd_addr, wr_addr;
    word_t rd_incr, wr_incr;
    word_t xdata, data;                         // last words read from XR and VRAM
    byte_t xdata_even, data_even;               // even bytes waiting for the odd one
    byte_t timer_lo;
    logic  vram_rd, xr_rd;                      // read outstanding
    logic  mem_wait;
    word_t rd_word;

    assign mem_wait = mem_req_o.wr | vram_rd | xr_rd;

    always_comb begin
        case (evt_i.reg_num)
            REG_SYS_CTRL: rd_word = {mem_wait, 4'b0, v_blank_i, 6'b0, mem_req_o.wrmask};
            REG_INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            REG_TIMER:    rd_word = {timer_count_i[15:8], timer_lo};
            REG_RD_XADDR: rd_word = rd_xaddr;
            REG_WR_XADDR: rd_word = wr_xaddr;
            REG_XDATA:    rd_word = xdata;
            REG_RD_INCR:  rd_word = rd_incr;
            REG_RD_ADDR:  rd_word = rd_addr;
            REG_WR_INCR:  rd_word = wr_incr;
            REG_WR_ADDR:  rd_word = wr_addr;
            default:      rd_word = data;
        endcase
    end

    assign bus_data_o = evt_i.bytesel ? rd_word[7:0] : rd_word[15:8];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_req_o        <= '0;
            mem_req_o.wrmask <= 4'hF;
            vram_rd          <= 1'b0;
            xr_rd            <= 1'b0;
            rd_xaddr         <= '0;
            wr_xaddr         <= '0;
            rd_addr          <= '0;
            wr_addr          <= '0;
            rd_incr          <= '0;
            wr_incr          <= '0;
            timer_cmp_o      <= 16'hFFFF;
            intr_mask_o      <= '0;
            intr_clear_o     <= '0;
            xdata            <= '0;
            data             <= '0;
            xdata_even       <= '0;
            data_even        <= '0;
            timer_lo         <= '0;
        end else begin
            intr_clear_o <= '0;

            if (vram_ack_i) begin
                if (vram_rd) begin
                    data    <= vram_rdata_i;
                    rd_addr <= rd_addr + rd_incr;
                end
                if (mem_req_o.wr) begin
                    wr_addr <= wr_addr + wr_incr;
                end
                mem_req_o.vram_sel <= 1'b0;
                mem_req_o.wr       <= 1'b0;
                vram_rd            <= 1'b0;
            end

            if (xr_ack_i) begin
                if (xr_rd) begin
                    xdata    <= xr_rdata_i;
                    rd_xaddr <= rd_xaddr + 16'd1;
                end
                if (mem_req_o.wr) begin
                    wr_xaddr <= wr_xaddr + 16'd1;
                end
                mem_req_o.xr_sel <= 1'b0;
                mem_req_o.wr     <= 1'b0;
                xr_rd            <= 1'b0;
            end

            // register writes come after the acks so a new request wins
            if (evt_i.wr_stb) begin
                case (evt_i.reg_num)
                    REG_SYS_CTRL: begin
                        if (evt_i.bytesel) mem_req_o.wrmask <= evt_i.data[3:0];
                    end
                    REG_INT_CTRL: begin
                        if (!evt_i.bytesel) intr_mask_o <= evt_i.data[6:0];
                        else                intr_clear_o <= evt_i.data[6:0];
                    end
                    REG_TIMER: begin
                        if (!evt_i.bytesel) timer_cmp_o[15:8] <= evt_i.data;
                        else                timer_cmp_o[7:0]  <= evt_i.data;
                    end
                    REG_RD_XADDR: begin
                        if (!evt_i.bytesel) begin
                            rd_xaddr[15:8] <= evt_i.data;
                        end else begin
                            rd_xaddr[7:0]    <= evt_i.data;
                            mem_req_o.xr_sel <= 1'b1;       // prefetch from new address
                            mem_req_o.wr     <= 1'b0;
                            mem_req_o.addr   <= {rd_xaddr[15:8], evt_i.data};
                            xr_rd            <= 1'b1;
                        end
                    end
                    REG_WR_XADDR: begin
                        if (!evt_i.bytesel) wr_xaddr[15:8] <= evt_i.data;
                        else                wr_xaddr[7:0]  <= evt_i.data;
                    end
                    REG_XDATA: begin
                        if (!evt_i.bytesel) begin
                            xdata_even <= evt_i.data;
                        end else begin
                            mem_req_o.xr_sel <= 1'b1;
                            mem_req_o.wr     <= 1'b1;
                            mem_req_o.addr   <= wr_xaddr;
                            mem_req_o.data   <= {xdata_even, evt_i.data};
                        end
                    end
                    REG_RD_INCR: begin
                        if (!evt_i.bytesel) rd_incr[15:8] <= evt_i.data;
                        else                rd_incr[7:0]  <= evt_i.data;
                    end
                    REG_RD_ADDR: begin
                        if (!evt_i.bytesel) begin
                            rd_addr[15:8] <= evt_i.data;
                        end else begin
                            rd_addr[7:0]       <= evt_i.data;
                            mem_req_o.vram_sel <= 1'b1;     // prefetch from new address
                            mem_req_o.wr       <= 1'b0;
                            mem_req_o.addr     <= {rd_addr[15:8], evt_i.data};
                            vram_rd            <= 1'b1;
                        end
                    end
                    REG_WR_INCR: begin
                        if (!evt_i.bytesel) wr_incr[15:8] <= evt_i.data;
                        else                wr_incr[7:0]  <= evt_i.data;
                    end
                    REG_WR_ADDR: begin
                        if (!evt_i.bytesel) wr_addr[15:8] <= evt_i.data;
                        else                wr_addr[7:0]  <= evt_i.data;
                    end
                    REG_DATA: begin
                        if (!evt_i.bytesel) begin
                            data_even <= evt_i.data;
                        end else begin
                            mem_req_o.vram_sel <= 1'b1;
                            mem_req_o.wr       <= 1'b1;
                            mem_req_o.addr     <= wr_addr;
                            mem_req_o.data     <= {data_even, evt_i.data};
                        end
                    end
                    default: begin                          // 11 to 15 ignore writes
                    end
                endcase
            end

            if (evt_i.rd_stb) begin
                if (!evt_i.bytesel) begin
                    timer_lo <= timer_count_i[7:0];         // stable low byte for next read
                end else if (evt_i.reg_num == REG_XDATA) begin
                    mem_req_o.xr_sel <= 1'b1;               // next XR word
                    mem_req_o.wr     <= 1'b0;
                    mem_req_o.addr   <= rd_xaddr;
                    xr_rd            <= 1'b1;
                end else if (evt_i.reg_num == REG_DATA) begin
                    mem_req_o.vram_sel <= 1'b1;             // next VRAM word
                    mem_req_o.wr       <= 1'b0;
                    mem_req_o.addr     <= rd_addr;
                    vram_rd            <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the video register testbench with Verilator
rm -f sim.log
{ verilator --binary --timing -f build.f --top-module tb_video_regs -o vsim \
    && ./obj_dir/vsim ; } > sim.log 2>&1 \
    || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== tb_video_regs.sv ====
// ----------------------------------------------------------------------
// directed testbench for the video controller host register block
//   CPU bus byte and word tasks, busy polling, value check
//   reset, VRAM, nibble mask, XR, interrupt and timer tests
//   cycle counter timeout and closing result line
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_video_regs;
    import bus_defs_pkg::*;
    import mem_defs_pkg::*;

    // far above about 160 bus accesses of 8 clocks each
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int TIMER_WAIT     = 4 * TIMER_TICK * 3;
    localparam int IDLE_POLLS     = 16;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic       bus_bytesel_i;
    logic [3:0] bus_reg_num_i;
    byte_t      bus_data_i;
    byte_t      bus_data_o;
    logic       v_blank_i;
    logic       intr_o;

    word_t       vram_model [256];
    word_t       xr_model [16];
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    video_regs_top u_video_regs_top (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .v_blank_i     (v_blank_i),
        .intr_o        (intr_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                      // 100 ns period

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: no result after %0d cycles", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic bus_write(input logic [3:0] reg_num, input logic byte_sel, input byte_t data);
        bus_reg_num_i = reg_num;
        bus_bytesel_i = byte_sel;
        bus_data_i    = data;
        bus_rd_nwr_i  = 1'b0;
        bus_cs_n_i    = 1'b0;
        repeat (5) @(negedge clk);
        bus_cs_n_i = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    task automatic bus_read(input logic [3:0] reg_num, input logic byte_sel, output byte_t data);
        bus_reg_num_i = reg_num;
        bus_bytesel_i = byte_sel;
        bus_rd_nwr_i  = 1'b1;
        bus_cs_n_i    = 1'b0;
        repeat (4) @(negedge clk);
        data = bus_data_o;                      // event latched one clock earlier
        @(negedge clk);
        bus_cs_n_i = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    task automatic write_word(input logic [3:0] reg_num, input word_t word);
        bus_write(reg_num, 1'b0, word[15:8]);
        bus_write(reg_num, 1'b1, word[7:0]);
    endtask

    task automatic read_word(input logic [3:0] reg_num, output word_t word);
        byte_t hi;
        byte_t lo;
        bus_read(reg_num, 1'b0, hi);
        bus_read(reg_num, 1'b1, lo);
        word = {hi, lo};
    endtask

    task automatic wait_idle();
        byte_t status;
        int    polls;
        polls = 0;
        bus_read(REG_SYS_CTRL, 1'b0, status);
        while (status[7] && polls < IDLE_POLLS) begin
            polls = polls + 1;
            bus_read(REG_SYS_CTRL, 1'b0, status);
        end
        if (status[7]) begin
            error_count = error_count + 1;
            $display("memory access still busy after %0d status polls", polls);
        end
    endtask

    // one bit per nibble
    function automatic word_t nibble_mask(input logic [3:0] mask);
        word_t bits;
        for (int n = 0; n < 4; n++) begin
            bits[n*4 +: 4] = {4{mask[n]}};
        end
        return bits;
    endfunction

    task automatic test_reset();
        word_t w;
        read_word(REG_RD_INCR, w);
        check("reset rd_incr", 16'h0000, w);
        read_word(REG_WR_ADDR, w);
        check("reset wr_addr", 16'h0000, w);
        read_word(REG_WR_INCR, w);
        check("reset wr_incr", 16'h0000, w);
        read_word(REG_SYS_CTRL, w);
        check("reset wrmask", 16'h000F, {12'h000, w[3:0]});
        read_word(REG_INT_CTRL, w);
        check("reset int_ctrl", 16'h0000, w);
    endtask

    task automatic test_vram_incr();
        word_t w;
        addr_t wr_exp;
        addr_t rd_exp;
        write_word(REG_WR_INCR, 16'd3);
        write_word(REG_WR_ADDR, 16'd16);
        wr_exp = 16'd16;
        for (int i = 0; i < 8; i++) begin
            w = 16'($urandom());
            vram_model[wr_exp[7:0]] = w;
            write_word(REG_DATA, w);
            wr_exp = wr_exp + 16'd3;
        end
        read_word(REG_WR_ADDR, w);
        check("vram wr_addr", wr_exp, w);
        write_word(REG_RD_INCR, 16'd3);
        write_word(REG_RD_ADDR, 16'd16);
        rd_exp = 16'd19;                        // prefetch already stepped once
        for (int i = 0; i < 8; i++) begin
            wait_idle();
            read_word(REG_DATA, w);
            check("vram data", vram_model[8'(16 + 3 * i)], w);
            rd_exp = rd_exp + 16'd3;
            read_word(REG_RD_ADDR, w);
            check("vram rd_addr", rd_exp, w);
        end
    endtask

    task automatic test_nibble_mask();
        word_t w;
        write_word(REG_WR_INCR, 16'd0);
        write_word(REG_WR_ADDR, 16'd100);
        write_word(REG_DATA, 16'hFFFF);
        vram_model[100] = 16'hFFFF;
        bus_write(REG_SYS_CTRL, 1'b1, 8'h05);
        write_word(REG_DATA, 16'h0000);
        vram_model[100] = vram_model[100] & ~nibble_mask(4'b0101);
        read_word(REG_SYS_CTRL, w);
        check("wrmask readback", 16'h0005, {12'h000, w[3:0]});
        write_word(REG_RD_ADDR, 16'd100);
        wait_idle();
        read_word(REG_DATA, w);
        check("nibble mask", vram_model[100], w);
        bus_write(REG_SYS_CTRL, 1'b1, 8'h0F);   // all nibbles again
    endtask

    task automatic test_xr();
        word_t w;
        write_word(REG_WR_XADDR, 16'd2);
        for (int i = 0; i < 4; i++) begin
            w = 16'($urandom());
            xr_model[4'(2 + i)] = w;
            write_word(REG_XDATA, w);
        end
        read_word(REG_WR_XADDR, w);
        check("xr wr_xaddr", 16'd2 + 16'd4, w);
        write_word(REG_RD_XADDR, 16'd2);
        for (int i = 0; i < 4; i++) begin
            wait_idle();
            read_word(REG_XDATA, w);
            check("xr data", xr_model[4'(2 + i)], w);
        end
        read_word(REG_RD_XADDR, w);
        check("xr rd_xaddr", 16'd2 + 16'd4 + 16'd1, w);
    endtask

    task automatic test_interrupts();
        word_t w;
        int    waited;
        bus_write(REG_INT_CTRL, 1'b0, 8'h02);   // enable vertical blank
        v_blank_i = 1'b1;
        waited = 0;
        while (!intr_o && waited < 8) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!intr_o) begin
            error_count = error_count + 1;
            $display("intr_o did not rise after vertical blank");
        end
        read_word(REG_SYS_CTRL, w);
        check("v_blank status", 16'h0400, w & 16'h0400);
        read_word(REG_INT_CTRL, w);
        check("vblank pending", 16'h0202, w);
        check("intr_o set", 16'h0001, {15'b0, intr_o});
        bus_write(REG_INT_CTRL, 1'b1, 8'h02);
        read_word(REG_INT_CTRL, w);
        check("vblank cleared", 16'h0200, w);
        check("intr_o cleared", 16'h0000, {15'b0, intr_o});
        v_blank_i = 1'b0;
        bus_write(REG_INT_CTRL, 1'b0, 8'h00);   // mask everything off
        v_blank_i = 1'b1;
        repeat (4) @(negedge clk);
        read_word(REG_INT_CTRL, w);
        check("masked pending", 16'h0002, w);
        check("intr_o masked", 16'h0000, {15'b0, intr_o});
        v_blank_i = 1'b0;
        bus_write(REG_INT_CTRL, 1'b1, 8'h02);
    endtask

    task automatic test_timer();
        word_t w;
        byte_t b;
        int    start;
        logic  seen;
        bus_read(REG_INT_CTRL, 1'b1, b);
        check("timer idle", 16'h0000, {15'b0, b[0]});
        write_word(REG_TIMER, 16'd2);
        start = cycle_count;
        seen  = 1'b0;
        while (!seen && cycle_count - start < TIMER_WAIT) begin
            bus_read(REG_INT_CTRL, 1'b1, b);
            seen = b[0];
        end
        check("timer pending", 16'h0001, {15'b0, seen});
        for (int i = 0; i < 6; i++) begin
            read_word(REG_TIMER, w);
            check("timer range", 16'h0001, {15'b0, w <= 16'd2});
        end
    endtask

    initial begin
        void'($urandom(32'h9a9a));
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = 4'd0;
        bus_data_i    = 8'h00;
        v_blank_i     = 1'b0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        test_reset();
        test_vram_incr();
        test_nibble_mask();
        test_xr();
        test_interrupts();
        test_timer();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tick_timer.sv ====
// ----------------------------------------------------------------------
// tick timer
//   prescaler of TIMER_TICK clocks, 16-bit count
//   reload to zero at the compare value with a one-cycle interrupt
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tick_timer (
    input  logic                clk,
    input  logic                reset_i,
    input  bus_defs_pkg::word_t cmp_i,
    output bus_defs_pkg::word_t count_o,
    output logic                intr_o
);
    import mem_defs_pkg::*;

    logic [$clog2(TIMER_TICK)-1:0] presc;
    logic                          tick;

    assign tick = (presc == $bits(presc)'(TIMER_TICK - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            presc   <= '0;
            count_o <= '0;
            intr_o  <= 1'b0;
        end else begin
            intr_o <= 1'b0;
            presc  <= tick ? '0 : presc + 1'b1;
            if (tick) begin
                if (count_o >= cmp_i) begin
                    count_o <= '0;              // compare reached
                    intr_o  <= 1'b1;
                end else begin
                    count_o <= count_o + 16'd1;
                end
            end
        end
    end

endmodule

// ==== video_regs_top.sv ====
// ----------------------------------------------------------------------
// video controller host register block, top level
//   bus synchronizer, register control, VRAM, XR register file,
//   tick timer and interrupt controller
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module video_regs_top (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,
    input  logic                bus_rd_nwr_i,
    input  logic [3:0]          bus_reg_num_i,
    input  logic                bus_bytesel_i,
    input  bus_defs_pkg::byte_t bus_data_i,
    output bus_defs_pkg::byte_t bus_data_o,
    input  logic                v_blank_i,
    output logic                intr_o
);
    import bus_defs_pkg::*;
    import mem_defs_pkg::*;

    bus_evt_t evt;
    mem_req_t mem_req;
    logic     vram_ack, xr_ack;
    word_t    vram_rdata, xr_rdata;
    word_t    timer_count, timer_cmp;
    logic     timer_intr;
    intr_t    intr_mask, intr_clear, intr_status;

    bus_sync u_bus_sync (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .evt_o         (evt)
    );

    reg_ctrl u_reg_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .evt_i         (evt),
        .bus_data_o    (bus_data_o),
        .mem_req_o     (mem_req),
        .vram_ack_i    (vram_ack),
        .xr_ack_i      (xr_ack),
        .vram_rdata_i  (vram_rdata),
        .xr_rdata_i    (xr_rdata),
        .v_blank_i     (v_blank_i),
        .timer_count_i (timer_count),
        .timer_cmp_o   (timer_cmp),
        .intr_mask_o   (intr_mask),
        .intr_clear_o  (intr_clear),
        .intr_status_i (intr_status)
    );

    vram_mem u_vram_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (mem_req),
        .ack_o   (vram_ack),
        .rdata_o (vram_rdata)
    );

    xr_regs u_xr_regs (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (mem_req),
        .ack_o   (xr_ack),
        .rdata_o (xr_rdata)
    );

    tick_timer u_tick_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .cmp_i   (timer_cmp),
        .count_o (timer_count),
        .intr_o  (timer_intr)
    );

    intr_ctrl u_intr_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .timer_intr_i (timer_intr),
        .v_blank_i    (v_blank_i),
        .mask_i       (intr_mask),
        .clear_i      (intr_clear),
        .status_o     (intr_status),
        .intr_o       (intr_o)
    );

endmodule

// ==== vram_mem.sv ====
// ----------------------------------------------------------------------
// video RAM
//   256 words with nibble write enables
//   registered read word and one-cycle ack per access
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module vram_mem (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mem_defs_pkg::mem_req_t req_i,
    output logic                   ack_o,
    output bus_defs_pkg::word_t    rdata_o
);
    import bus_defs_pkg::*;
    import mem_defs_pkg::*;

    word_t              mem [2**VRAM_AW];
    logic [VRAM_AW-1:0] addr;
    logic               start;

    assign addr  = req_i.addr[VRAM_AW-1:0];
    assign start = req_i.vram_sel & ~ack_o;     // select still high while acking

    always_ff @(posedge clk) begin
        if (reset_i) ack_o <= 1'b0;
        else         ack_o <= start;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rdata_o <= mem[addr];
            if (req_i.wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (req_i.wrmask[i]) mem[addr][i*4 +: 4] <= req_i.data[i*4 +: 4];
                end
            end
        end
    end

endmodule

// ==== xr_regs.sv ====
// ----------------------------------------------------------------------
// extended register file
//   16 words cleared on reset, whole-word writes
//   registered read word and one-cycle ack per access
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module xr_regs (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mem_defs_pkg::mem_req_t req_i,
    output logic                   ack_o,
    output bus_defs_pkg::word_t    rdata_o
);
    import bus_defs_pkg::*;
    import mem_defs_pkg::*;

    word_t            regs [2**XR_AW];
    logic [XR_AW-1:0] addr;
    logic             start;

    assign addr  = req_i.addr[XR_AW-1:0];
    assign start = req_i.xr_sel & ~ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
            for (int i = 0; i < 2**XR_AW; i++) regs[i] <= '0;
        end else begin
            ack_o <= start;
            if (start && req_i.wr) regs[addr] <= req_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (start) rdata_o <= regs[addr];
    end

endmodule
